// File: logic/fe_config.svh
// build constants of the RV32I fetch front end: widths, queue depth, reset vector, opcodes
`ifndef FE_CONFIG_SVH
`define FE_CONFIG_SVH

// ---------------------------------------------------------------------------
// datapath
// ---------------------------------------------------------------------------
// address and instruction width
`define FE_XLEN 32
// fetch queue entries, power of two of 2 or more
`define FE_QUEUE_DEPTH 4
// default reset vector
`define FE_BOOT_ADDR 32'h0000_0080

// ---------------------------------------------------------------------------
// major opcodes scanned by predecode
// ---------------------------------------------------------------------------
`define FE_OP_JAL    7'b1101111
`define FE_OP_JALR   7'b1100111
`define FE_OP_BRANCH 7'b1100011

`endif

// File: logic/fe_pkg.sv
// shared types of the fetch front end: address, instruction, queue pointer, control-flow kind
`include "fe_config.svh"

package fe_pkg;

    // ---------------------------------------------------------------------------
    // datapath words
    // ---------------------------------------------------------------------------
    // instruction address, always word aligned on the fetch side
    typedef logic [`FE_XLEN-1:0] addr_t;

    // raw 32 bit instruction word as returned by memory
    typedef logic [`FE_XLEN-1:0] instr_t;

    // fetch queue read/write pointer
    // wraps on its own since the depth is a power of two
    typedef logic [$clog2(`FE_QUEUE_DEPTH)-1:0] ptr_t;

    // ---------------------------------------------------------------------------
    // control flow classification of a fetch entry
    // ---------------------------------------------------------------------------
    // kind only, taken is carried separately
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JUMP   = 2'd2
    } cf_e;

endpackage

// File: logic/fe_pc_gen.sv
// fetch PC generation with next-PC priority select, memory request and live response forwarding
`timescale 1ns/1ns
`include "fe_config.svh"

module fe_pc_gen (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  fe_pkg::addr_t  boot_addr_i,
    // single-cycle back-end redirect pulses
    input  logic           set_pc_commit_i,
    input  fe_pkg::addr_t  pc_commit_i,
    input  logic           ex_valid_i,
    input  fe_pkg::addr_t  trap_vector_i,
    input  logic           eret_i,
    input  fe_pkg::addr_t  epc_i,
    input  logic           mispredict_i,
    input  fe_pkg::addr_t  mispredict_target_i,
    // front-end internal redirects
    input  logic           bp_taken_i,
    input  fe_pkg::addr_t  bp_target_i,
    input  logic           replay_i,
    input  fe_pkg::addr_t  replay_addr_i,
    // instruction memory
    output logic           fetch_req_o,
    output fe_pkg::addr_t  fetch_addr_o,
    input  logic           fetch_rvalid_i,
    input  fe_pkg::instr_t fetch_rdata_i,
    // towards predecode
    output logic           rsp_valid_o,
    output fe_pkg::addr_t  rsp_addr_o,
    output fe_pkg::instr_t rsp_instr_o,
    output logic           flush_o
);

    fe_pkg::addr_t npc_d;
    fe_pkg::addr_t npc_q;
    fe_pkg::addr_t fetch_addr;
    // set while coming out of reset so the boot address gets loaded
    logic          npc_rst_load_q;
    // request outstanding in memory and its address
    logic          req_pending_q;
    fe_pkg::addr_t req_addr_q;
    // drop the response arriving in a redirect cycle
    logic          kill_rsp;

    // ---------------------------------------------------------------------------
    // redirect sources
    // ---------------------------------------------------------------------------
    // any back-end redirect flushes predecode and queue
    assign flush_o  = set_pc_commit_i | ex_valid_i | eret_i | mispredict_i;
    // response in flight belongs to the old path
    assign kill_rsp = flush_o | replay_i | bp_taken_i;

    // ---------------------------------------------------------------------------
    // next PC where later assignments win
    // ---------------------------------------------------------------------------
    always_comb begin : npc_select
        fetch_addr = npc_rst_load_q ? boot_addr_i : npc_q;
        // static prediction from predecode
        if (bp_taken_i) begin
            fetch_addr = bp_target_i;
        end
        // refetch of a word the queue rejected
        if (replay_i) begin
            fetch_addr = replay_addr_i;
        end
        if (mispredict_i) begin
            fetch_addr = mispredict_target_i;
        end
        if (eret_i) begin
            fetch_addr = epc_i;
        end
        if (ex_valid_i) begin
            fetch_addr = trap_vector_i;
        end
        // commit flush restarts after the committing instruction
        if (set_pc_commit_i) begin
            fetch_addr = pc_commit_i + fe_pkg::addr_t'(4);
        end
        // no request in the load cycle and hence no increment
        npc_d = npc_rst_load_q ? fetch_addr : fetch_addr + fe_pkg::addr_t'(4);
    end

    assign fetch_req_o  = ~npc_rst_load_q;
    assign fetch_addr_o = fetch_addr;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_rst_load_q <= 1'b1;
            npc_q          <= '0;
            req_pending_q  <= 1'b0;
        end else begin
            npc_rst_load_q <= 1'b0;
            npc_q          <= npc_d;
            req_pending_q  <= fetch_req_o;
        end
    end

    // request address that pairs with next cycle's rdata
    always_ff @(posedge clk_i) begin
        if (fetch_req_o) begin
            req_addr_q <= fetch_addr;
        end
    end

    // ---------------------------------------------------------------------------
    // response forwarding
    // ---------------------------------------------------------------------------
    assign rsp_valid_o = fetch_rvalid_i & req_pending_q & ~kill_rsp;
    assign rsp_addr_o  = req_addr_q;
    assign rsp_instr_o = fetch_rdata_i;

endmodule

// File: logic/fe_predecode.sv
// predecode stage: registers a fetched word, scans its opcode and applies static prediction
`timescale 1ns/1ns
`include "fe_config.svh"

module fe_predecode (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           flush_i,
    // queue replay, the stage word was rejected
    input  logic           kill_i,
    // live response from PC generation
    input  logic           rsp_valid_i,
    input  fe_pkg::addr_t  rsp_addr_i,
    input  fe_pkg::instr_t rsp_instr_i,
    // entry towards the fetch queue
    output logic           push_o,
    output fe_pkg::addr_t  entry_addr_o,
    output fe_pkg::instr_t entry_instr_o,
    output fe_pkg::cf_e    entry_cf_o,
    output logic           entry_taken_o,
    output fe_pkg::addr_t  entry_target_o,
    // prediction back to PC generation
    output logic           bp_taken_o,
    output fe_pkg::addr_t  bp_target_o
);

    logic           stage_valid_q;
    fe_pkg::addr_t  stage_addr_q;
    fe_pkg::instr_t stage_instr_q;
    logic [6:0]     opcode;
    // sign extended J and B immediates
    fe_pkg::addr_t  imm_j;
    fe_pkg::addr_t  imm_b;
    fe_pkg::cf_e    cf;
    logic           taken;
    fe_pkg::addr_t  target;

    // ---------------------------------------------------------------------------
    // stage register
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_valid_q <= 1'b0;
        end else if (flush_i || kill_i) begin
            stage_valid_q <= 1'b0;
        end else begin
            stage_valid_q <= rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_valid_i) begin
            stage_addr_q  <= rsp_addr_i;
            stage_instr_q <= rsp_instr_i;
        end
    end

    // ---------------------------------------------------------------------------
    // opcode scan
    // ---------------------------------------------------------------------------
    assign opcode = stage_instr_q[6:0];
    assign imm_j  = {{12{stage_instr_q[31]}}, stage_instr_q[19:12], stage_instr_q[20],
                     stage_instr_q[30:21], 1'b0};
    assign imm_b  = {{20{stage_instr_q[31]}}, stage_instr_q[7], stage_instr_q[30:25],
                     stage_instr_q[11:8], 1'b0};

    always_comb begin : scan
        cf     = fe_pkg::CF_NONE;
        taken  = 1'b0;
        // fall-through unless predicted taken
        target = stage_addr_q + fe_pkg::addr_t'(4);
        case (opcode)
            // direct jump, always taken
            `FE_OP_JAL: begin
                cf     = fe_pkg::CF_JUMP;
                taken  = 1'b1;
                target = stage_addr_q + imm_j;
            end
            // backward taken, forward not taken
            `FE_OP_BRANCH: begin
                cf = fe_pkg::CF_BRANCH;
                if (imm_b[`FE_XLEN-1]) begin
                    taken  = 1'b1;
                    target = stage_addr_q + imm_b;
                end
            end
            // register target unknown here, never predicted
            `FE_OP_JALR: begin
                cf = fe_pkg::CF_JUMP;
            end
            default: begin
                cf = fe_pkg::CF_NONE;
            end
        endcase
    end

    assign push_o         = stage_valid_q;
    assign entry_addr_o   = stage_addr_q;
    assign entry_instr_o  = stage_instr_q;
    assign entry_cf_o     = cf;
    assign entry_taken_o  = taken;
    assign entry_target_o = target;
    assign bp_taken_o     = stage_valid_q & taken;
    assign bp_target_o    = target;

endmodule

// File: logic/fe_fetch_queue.sv
// fetch queue: circular buffer of predecoded entries towards decode, replays pushes that find it full
`timescale 1ns/1ns
`include "fe_config.svh"

module fe_fetch_queue (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           flush_i,
    // entry from predecode
    input  logic           push_i,
    input  fe_pkg::addr_t  entry_addr_i,
    input  fe_pkg::instr_t entry_instr_i,
    input  fe_pkg::cf_e    entry_cf_i,
    input  logic           entry_taken_i,
    input  fe_pkg::addr_t  entry_target_i,
    // rejected push, refetch from this address
    output logic           replay_o,
    output fe_pkg::addr_t  replay_addr_o,
    // head entry towards decode
    output logic           entry_valid_o,
    output fe_pkg::addr_t  entry_addr_o,
    output fe_pkg::instr_t entry_instr_o,
    output fe_pkg::cf_e    entry_cf_o,
    output logic           entry_taken_o,
    output fe_pkg::addr_t  entry_target_o,
    input  logic           entry_ack_i
);

    // entry storage
    fe_pkg::addr_t  addr_q   [`FE_QUEUE_DEPTH];
    fe_pkg::instr_t instr_q  [`FE_QUEUE_DEPTH];
    fe_pkg::cf_e    cf_q     [`FE_QUEUE_DEPTH];
    logic           taken_q  [`FE_QUEUE_DEPTH];
    fe_pkg::addr_t  target_q [`FE_QUEUE_DEPTH];

    fe_pkg::ptr_t                     rd_ptr_q;
    fe_pkg::ptr_t                     wr_ptr_q;
    logic [$clog2(`FE_QUEUE_DEPTH):0] count_q;
    logic                             full;
    logic                             pop;
    logic                             push_ok;

    // ---------------------------------------------------------------------------
    // occupancy and handshake
    // ---------------------------------------------------------------------------
    // count never exceeds the power-of-two depth, top bit alone means full
    assign full = count_q[$clog2(`FE_QUEUE_DEPTH)];
    assign pop  = entry_valid_o & entry_ack_i;

    // a pop in the same cycle frees the slot
    assign push_ok       = push_i & ~flush_i & (~full | pop);
    assign replay_o      = push_i & ~flush_i & full & ~pop;
    assign replay_addr_o = entry_addr_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ---------------------------------------------------------------------------
    // storage write and head read
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            addr_q[wr_ptr_q]   <= entry_addr_i;
            instr_q[wr_ptr_q]  <= entry_instr_i;
            cf_q[wr_ptr_q]     <= entry_cf_i;
            taken_q[wr_ptr_q]  <= entry_taken_i;
            target_q[wr_ptr_q] <= entry_target_i;
        end
    end

    assign entry_valid_o  = (count_q != '0);
    assign entry_addr_o   = addr_q[rd_ptr_q];
    assign entry_instr_o  = instr_q[rd_ptr_q];
    assign entry_cf_o     = cf_q[rd_ptr_q];
    assign entry_taken_o  = taken_q[rd_ptr_q];
    assign entry_target_o = target_q[rd_ptr_q];

endmodule

// File: logic/fe_top.sv
// RV32I instruction fetch front end: PC generation, predecode and fetch queue
`timescale 1ns/1ns

module fe_top (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  fe_pkg::addr_t  boot_addr_i,
    // back-end redirects
    input  logic           set_pc_commit_i,
    input  fe_pkg::addr_t  pc_commit_i,
    input  logic           ex_valid_i,
    input  fe_pkg::addr_t  trap_vector_i,
    input  logic           eret_i,
    input  fe_pkg::addr_t  epc_i,
    input  logic           mispredict_i,
    input  fe_pkg::addr_t  mispredict_target_i,
    // instruction memory
    output logic           fetch_req_o,
    output fe_pkg::addr_t  fetch_addr_o,
    input  logic           fetch_rvalid_i,
    input  fe_pkg::instr_t fetch_rdata_i,
    // towards decode
    output logic           entry_valid_o,
    output fe_pkg::addr_t  entry_addr_o,
    output fe_pkg::instr_t entry_instr_o,
    output fe_pkg::cf_e    entry_cf_o,
    output logic           entry_taken_o,
    output fe_pkg::addr_t  entry_target_o,
    input  logic           entry_ack_i
);

    // pc_gen to predecode
    logic           rsp_valid;
    fe_pkg::addr_t  rsp_addr;
    fe_pkg::instr_t rsp_instr;
    logic           flush;
    // predecode back to pc_gen
    logic           bp_taken;
    fe_pkg::addr_t  bp_target;
    // predecode to queue
    logic           push;
    fe_pkg::addr_t  pd_addr;
    fe_pkg::instr_t pd_instr;
    fe_pkg::cf_e    pd_cf;
    logic           pd_taken;
    fe_pkg::addr_t  pd_target;
    // queue back to pc_gen and predecode
    logic           replay;
    fe_pkg::addr_t  replay_addr;

    fe_pc_gen i_pc_gen (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .boot_addr_i         ( boot_addr_i         ),
        .set_pc_commit_i     ( set_pc_commit_i     ),
        .pc_commit_i         ( pc_commit_i         ),
        .ex_valid_i          ( ex_valid_i          ),
        .trap_vector_i       ( trap_vector_i       ),
        .eret_i              ( eret_i              ),
        .epc_i               ( epc_i               ),
        .mispredict_i        ( mispredict_i        ),
        .mispredict_target_i ( mispredict_target_i ),
        .bp_taken_i          ( bp_taken            ),
        .bp_target_i         ( bp_target           ),
        .replay_i            ( replay              ),
        .replay_addr_i       ( replay_addr         ),
        .fetch_req_o         ( fetch_req_o         ),
        .fetch_addr_o        ( fetch_addr_o        ),
        .fetch_rvalid_i      ( fetch_rvalid_i      ),
        .fetch_rdata_i       ( fetch_rdata_i       ),
        .rsp_valid_o         ( rsp_valid           ),
        .rsp_addr_o          ( rsp_addr            ),
        .rsp_instr_o         ( rsp_instr           ),
        .flush_o             ( flush               )
    );

    // replay doubles as the kill of the stage word
    fe_predecode i_predecode (
        .clk_i          ( clk_i     ),
        .rst_ni         ( rst_ni    ),
        .flush_i        ( flush     ),
        .kill_i         ( replay    ),
        .rsp_valid_i    ( rsp_valid ),
        .rsp_addr_i     ( rsp_addr  ),
        .rsp_instr_i    ( rsp_instr ),
        .push_o         ( push      ),
        .entry_addr_o   ( pd_addr   ),
        .entry_instr_o  ( pd_instr  ),
        .entry_cf_o     ( pd_cf     ),
        .entry_taken_o  ( pd_taken  ),
        .entry_target_o ( pd_target ),
        .bp_taken_o     ( bp_taken  ),
        .bp_target_o    ( bp_target )
    );

    fe_fetch_queue i_fetch_queue (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush          ),
        .push_i         ( push           ),
        .entry_addr_i   ( pd_addr        ),
        .entry_instr_i  ( pd_instr       ),
        .entry_cf_i     ( pd_cf          ),
        .entry_taken_i  ( pd_taken       ),
        .entry_target_i ( pd_target      ),
        .replay_o       ( replay         ),
        .replay_addr_o  ( replay_addr    ),
        .entry_valid_o  ( entry_valid_o  ),
        .entry_addr_o   ( entry_addr_o   ),
        .entry_instr_o  ( entry_instr_o  ),
        .entry_cf_o     ( entry_cf_o     ),
        .entry_taken_o  ( entry_taken_o  ),
        .entry_target_o ( entry_target_o ),
        .entry_ack_i    ( entry_ack_i    )
    );

endmodule

// File: dv/fe_chk.sv
// port assertions of the fetch front end: quiet reset, held entry valid, aligned fetch
`timescale 1ns/1ns

module fe_chk (
    input logic          clk_i,
    input logic          rst_ni,
    input logic          fetch_req_o,
    input fe_pkg::addr_t fetch_addr_o,
    input logic          entry_valid_o,
    input logic          entry_ack_i,
    input logic          set_pc_commit_i,
    input logic          ex_valid_i,
    input logic          eret_i,
    input logic          mispredict_i
);

    // any back-end redirect flushes the queue
    logic redirect;
    assign redirect = set_pc_commit_i | ex_valid_i | eret_i | mispredict_i;

    // ------------------------------------------------------------------------
    // properties
    // ------------------------------------------------------------------------
    reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !entry_valid_o && !fetch_req_o)
        else $error("entry valid or fetch request high during reset");

    // head entry stays until it is taken or flushed
    valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        entry_valid_o && !entry_ack_i && !redirect |=> entry_valid_o)
        else $error("entry valid dropped without ack or redirect");

    fetch_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_req_o |-> fetch_addr_o[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

bind fe_top fe_chk fe_chk_i (.*);

// File: dv/fe_tb.sv
// testbench of the fetch front end with memory model, redirect events, ack patterns and walker
`timescale 1ns/1ns
`include "fe_config.svh"

module fe_tb;

    localparam int RUN_CYCLES = 240;
    localparam int IDLE_LIMIT = 64;

    logic           clk_i = 1'b1;
    logic           rst_ni;
    fe_pkg::addr_t  boot_addr_i;
    logic           set_pc_commit_i;
    logic           ex_valid_i;
    logic           eret_i;
    logic           mispredict_i;
    fe_pkg::addr_t  pc_commit_i;
    fe_pkg::addr_t  trap_vector_i;
    fe_pkg::addr_t  epc_i;
    fe_pkg::addr_t  mispredict_target_i;
    logic           fetch_req_o;
    logic           fetch_rvalid_i;
    logic           entry_valid_o;
    logic           entry_taken_o;
    logic           entry_ack_i;
    fe_pkg::addr_t  fetch_addr_o;
    fe_pkg::addr_t  entry_addr_o;
    fe_pkg::addr_t  entry_target_o;
    fe_pkg::instr_t fetch_rdata_i;
    fe_pkg::instr_t entry_instr_o;
    fe_pkg::cf_e    entry_cf_o;

    // program image with unlisted words taken from the fill pattern
    fe_pkg::instr_t mem [fe_pkg::addr_t];
    int             ev_cycle[$];
    logic [3:0]     ev_mask[$];
    fe_pkg::addr_t  ev_value[$];
    int             ack_cycle[$];
    int             ack_mode[$];
    int             errors = 0;
    int             timeouts = 0;
    int             file_errors = 0;
    int             checked = 0;
    integer         seed;

    fe_top fe_top_i (.*);

    always #2 clk_i = ~clk_i;

    // non control-flow filler that depends on every address bit
    function automatic fe_pkg::instr_t mem_word(input fe_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a[31:7] ^ a[24:0], 7'h13};
    endfunction

    // ------------------------------------------------------------------------
    // reference walker with the static prediction rules
    // ------------------------------------------------------------------------
    task automatic predict(input fe_pkg::addr_t a, output fe_pkg::instr_t w,
                           output fe_pkg::cf_e cf, output logic tk, output fe_pkg::addr_t nxt);
        logic signed [31:0] off_j;
        logic signed [31:0] off_b;
        w     = mem_word(a);
        off_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        off_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        cf    = fe_pkg::CF_NONE;
        tk    = 1'b0;
        nxt   = a + 32'd4;
        if (w[6:0] == `FE_OP_JAL) begin
            cf  = fe_pkg::CF_JUMP;
            tk  = 1'b1;
            nxt = a + off_j;
        end else if (w[6:0] == `FE_OP_JALR) begin
            cf = fe_pkg::CF_JUMP;
        end else if (w[6:0] == `FE_OP_BRANCH) begin
            cf = fe_pkg::CF_BRANCH;
            // backward offsets predicted taken
            if (off_b < 0) begin
                tk  = 1'b1;
                nxt = a + off_b;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_addr(input string what, input fe_pkg::addr_t got,
                              input fe_pkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_instr(input fe_pkg::instr_t got, input fe_pkg::instr_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t instruction is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_cf(input fe_pkg::cf_e got, input fe_pkg::cf_e exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t cf kind is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_taken(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t taken is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic load_vectors();
        int            fd;
        int            n;
        string         line;
        logic [7:0]    tag;
        fe_pkg::addr_t f1;
        fe_pkg::addr_t f2;
        int            c;
        int            m;
        fd = $fopen("dv/fe_vectors.txt", "r");
        if (fd == 0) begin
            $display("vector file dv/fe_vectors.txt could not be opened");
            file_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                tag  = (n > 0) ? line[0] : 8'h23;
                if (tag == "M") begin
                    n = $sscanf(line, "M %h %h", f1, f2);
                    mem[f1] = f2;
                end else if (tag == "E") begin
                    n = $sscanf(line, "E %d %h %h", c, m, f1);
                    ev_cycle.push_back(c);
                    ev_mask.push_back(m[3:0]);
                    ev_value.push_back(f1);
                end else if (tag == "A") begin
                    n = $sscanf(line, "A %d %d", c, m);
                    ack_cycle.push_back(c);
                    ack_mode.push_back(m);
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin : main
        fe_pkg::addr_t  exp_addr;
        fe_pkg::addr_t  nxt;
        fe_pkg::addr_t  v;
        fe_pkg::instr_t w;
        fe_pkg::cf_e    cf;
        logic           tk;
        logic           req_seen;
        fe_pkg::addr_t  req_addr;
        logic [3:0]     mk;
        int             mode;
        int             idle;
        rst_ni = 1'b1;
        boot_addr_i = `FE_BOOT_ADDR;
        {set_pc_commit_i, ex_valid_i, eret_i, mispredict_i} = 4'b0;
        {pc_commit_i, trap_vector_i, epc_i, mispredict_target_i} = '0;
        fetch_rvalid_i = 1'b0;
        fetch_rdata_i  = '0;
        entry_ack_i    = 1'b0;
        seed     = 14;
        req_seen = 1'b0;
        req_addr = '0;
        mode     = 0;
        idle     = 0;
        load_vectors();
        // falling reset edge loads every register before the first rising clock
        @(negedge clk_i);
        rst_ni = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni   = 1'b1;
        exp_addr = boot_addr_i;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(negedge clk_i);
            // memory answers the request accepted at the last edge
            fetch_rvalid_i = req_seen;
            fetch_rdata_i  = req_seen ? mem_word(req_addr) : '0;
            mk = 4'b0;
            if (ev_cycle.size() > 0 && ev_cycle[0] == cyc) begin
                mk = ev_mask.pop_front();
                v  = ev_value.pop_front();
                void'(ev_cycle.pop_front());
                pc_commit_i         = v;
                trap_vector_i       = v + 32'h40;
                epc_i               = v + 32'h80;
                mispredict_target_i = v + 32'hc0;
                // highest ranked source sets the restart point
                if (mk[0]) begin
                    exp_addr = v + 32'd4;
                end else if (mk[1]) begin
                    exp_addr = v + 32'h40;
                end else if (mk[2]) begin
                    exp_addr = v + 32'h80;
                end else begin
                    exp_addr = v + 32'hc0;
                end
            end
            {mispredict_i, eret_i, ex_valid_i, set_pc_commit_i} = mk;
            if (ack_cycle.size() > 0 && ack_cycle[0] == cyc) begin
                void'(ack_cycle.pop_front());
                mode = ack_mode.pop_front();
            end
            // mode 0 acks every cycle and mode 1 withholds acks
            // mode 2 acks in random gaps and no mode acks in a redirect cycle
            entry_ack_i = (mk == 4'b0)
                          && (mode == 0 || (mode == 2 && $random(seed) % 2 != 0));
            #1;
            req_seen = fetch_req_o;
            req_addr = fetch_addr_o;
            // a redirect shows on the fetch address in its own cycle
            if (mk != 4'b0) begin
                check_addr("redirect fetch address", fetch_addr_o, exp_addr);
            end
            if (entry_ack_i && entry_valid_o) begin
                predict(exp_addr, w, cf, tk, nxt);
                check_addr("entry address", entry_addr_o, exp_addr);
                check_instr(entry_instr_o, w);
                check_cf(entry_cf_o, cf);
                check_taken(entry_taken_o, tk);
                check_addr("entry target", entry_target_o, nxt);
                exp_addr = nxt;
                checked++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > IDLE_LIMIT) begin
                $display("no entry was accepted for %0d cycles, giving up", IDLE_LIMIT);
                timeouts++;
                break;
            end
        end
        $display("entries checked %0d, value errors %0d, timeouts %0d, file errors %0d",
                 checked, errors, timeouts, file_errors);
        if (errors == 0 && timeouts == 0 && file_errors == 0 && checked > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+logic
logic/fe_pkg.sv
logic/fe_pc_gen.sv
logic/fe_predecode.sv
logic/fe_fetch_queue.sv
logic/fe_top.sv
dv/fe_chk.sv
dv/fe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fe_tb \
    -f build.f -o fe_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fe_sim > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST OK" sim.log || exit 1
exit 0

// File: dv/fe_vectors.txt
# M address word      : program memory, hex
# E cycle mask value  : redirect pulse, mask bit0 commit, bit1 trap, bit2 eret, bit3 mispredict
# A cycle mode        : ack from cycle on, 0 always, 1 withheld, 2 random gaps
M 00000080 00000013
M 00000084 00000013
M 00000088 0100006f
M 00000098 00000463
M 0000009c 00008067
M 000000a0 fe000ce3
A 0 0
E 30 1 00000100
E 45 2 00000200
E 55 4 00000300
A 60 1
A 100 2
E 140 8 00000400
E 160 f 00000080
A 200 0
E 215 2 00000500
